// File: hw/exc_pkg.sv
// Shared constants and state types for the exception sequencer.
// Descriptors are 8 bytes wide: configuration word at +0, handler word at +4.
// The table has 64 entries, so the interrupt number is 6 bits wide.
package exc_pkg;

	// Data and address width
	localparam int unsigned WORD_W = 32;

	// Interrupt descriptor table geometry
	localparam int unsigned IDT_ENTRIES = 64;
	localparam int unsigned IDX_W = $clog2(IDT_ENTRIES);
	localparam int unsigned DESC_STRIDE = 8;
	localparam int unsigned HANDLER_OFFSET = 4;

	// Interrupt enable flag in PSR
	localparam int unsigned PSR_IRQ_EN_BIT = 2;

	// Configuration word fields, level is two bits wide
	localparam int unsigned ICT_VALID_BIT = 0;
	localparam int unsigned ICT_MASK_BIT = 1;
	localparam int unsigned ICT_LEVEL_LSB = 16;

	typedef enum logic [2:0] {
		IDLE,
		JUMP,
		IRQ_SET,
		IRQ_RET,
		IDTS
	} main_state_t;

	// Request from the main FSM to the table reader
	typedef enum logic [1:0] {
		NONE,
		HANDLER,
		TABLE
	} read_mode_t;

endpackage

// File: hw/exception_ctrl.sv
// Main exception FSM of the core.
// Events are sampled only in IDLE, with priority jump, interrupt, return, IDT set.
// All strobe outputs are single-cycle pulses; pc and the other payloads are
// only meaningful while their strobe is high.
module exception_ctrl (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic except_jump,
	input  logic except_ib,
	input  logic except_idts,
	input  logic [exc_pkg::WORD_W-1:0] jump_addr,
	input  logic irq_req,
	input  logic [exc_pkg::IDX_W-1:0] irq_num,
	input  logic [exc_pkg::WORD_W-1:0] irq_fi0r,
	input  logic interrupt_lock,
	input  logic [exc_pkg::WORD_W-1:0] psr,
	input  logic [exc_pkg::WORD_W-1:0] pcr,
	input  logic [exc_pkg::WORD_W-1:0] ppcr,
	input  logic [exc_pkg::WORD_W-1:0] idtr,
	input  logic read_done,
	input  logic [exc_pkg::WORD_W-1:0] handler_addr,
	output logic pipeline_stop,
	output logic refresh,
	output logic pc_set,
	output logic [exc_pkg::WORD_W-1:0] pc,
	output logic ppcr_set,
	output logic [exc_pkg::WORD_W-1:0] ppcr_out,
	output logic fi0r_set,
	output logic [exc_pkg::WORD_W-1:0] fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic irq_ack,
	output logic ldst_use,
	output logic read_start,
	output exc_pkg::read_mode_t read_mode,
	output logic [exc_pkg::WORD_W-1:0] idtr_q,
	output logic [exc_pkg::IDX_W-1:0] irq_num_q
);

	exc_pkg::main_state_t state;
	// Substep inside the current main state
	logic [1:0] step;
	logic [exc_pkg::WORD_W-1:0] ppcr_q;
	logic irq_ok;

	assign irq_ok = irq_req && !interrupt_lock && psr[exc_pkg::PSR_IRQ_EN_BIT];

	// Stall already in the sampling cycle when an interrupt will be taken
	assign pipeline_stop = (state != exc_pkg::IDLE) || (!except_jump && irq_ok);

	assign ldst_use = (state == exc_pkg::IRQ_SET) || (state == exc_pkg::IRQ_RET) ||
		(state == exc_pkg::IDTS);

	// Handler word is in pc, jump follows next cycle
	assign fi0r_set = (state == exc_pkg::IRQ_SET) && (step == 2'd2);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= exc_pkg::IDLE;
			step <= 2'd0;
			refresh <= 1'b0;
			pc_set <= 1'b0;
			ppcr_set <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			irq_ack <= 1'b0;
			read_start <= 1'b0;
			read_mode <= exc_pkg::NONE;
		end else begin
			refresh <= 1'b0;
			pc_set <= 1'b0;
			ppcr_set <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			irq_ack <= 1'b0;
			read_start <= 1'b0;
			read_mode <= exc_pkg::NONE;
			case (state)
				exc_pkg::IDLE: begin
					step <= 2'd0;
					if (except_jump) begin
						state <= exc_pkg::JUMP;
						refresh <= 1'b1;
					end else if (irq_ok) begin
						state <= exc_pkg::IRQ_SET;
						refresh <= 1'b1;
						ppcr_set <= 1'b1;
						set_irq_mode <= 1'b1;
					end else if (except_ib) begin
						state <= exc_pkg::IRQ_RET;
						refresh <= 1'b1;
					end else if (except_idts) begin
						state <= exc_pkg::IDTS;
						refresh <= 1'b1;
					end
				end
				exc_pkg::JUMP: begin
					pc_set <= 1'b1;
					state <= exc_pkg::IDLE;
				end
				exc_pkg::IRQ_SET: begin
					case (step)
						2'd0: begin
							read_start <= 1'b1;
							read_mode <= exc_pkg::HANDLER;
							step <= 2'd1;
						end
						2'd1: begin
							if (read_done) begin
								step <= 2'd2;
							end
						end
						default: begin
							pc_set <= 1'b1;
							irq_ack <= 1'b1;
							state <= exc_pkg::IDLE;
						end
					endcase
				end
				exc_pkg::IRQ_RET: begin
					// One cycle to move the saved PC over, then jump back
					if (step == 2'd0) begin
						step <= 2'd1;
					end else begin
						pc_set <= 1'b1;
						clr_irq_mode <= 1'b1;
						state <= exc_pkg::IDLE;
					end
				end
				exc_pkg::IDTS: begin
					if (step == 2'd0) begin
						read_start <= 1'b1;
						read_mode <= exc_pkg::TABLE;
						step <= 2'd1;
					end else if (read_done) begin
						pc_set <= 1'b1;
						state <= exc_pkg::IDLE;
					end
				end
				default: begin
					state <= exc_pkg::IDLE;
				end
			endcase
		end
	end

	// Payload registers, qualified by the strobes above
	always_ff @(posedge iCLOCK) begin
		if (state == exc_pkg::IDLE) begin
			ppcr_q <= ppcr;
			idtr_q <= idtr;
			if (except_jump) begin
				pc <= jump_addr;
			end else if (irq_ok) begin
				ppcr_out <= pcr;
				irq_num_q <= irq_num;
				fi0r <= irq_fi0r;
			end else if (!except_ib && except_idts) begin
				// Resume address after the table load
				pc <= jump_addr;
			end
		end else if (state == exc_pkg::IRQ_SET && read_done) begin
			pc <= handler_addr;
		end else if (state == exc_pkg::IRQ_RET && step == 2'd0) begin
			pc <= ppcr_q;
		end
	end

endmodule

// File: hw/idt_reader.sv
// Read engine for the interrupt descriptor table.
// Handler mode reads one word at idtr + num * 8 + 4; table mode reads all
// 64 configuration words at idtr + entry * 8.
// Responses must come back in issue order, one per ldst_valid pulse.
module idt_reader (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic read_start,
	input  exc_pkg::read_mode_t read_mode,
	input  logic [exc_pkg::WORD_W-1:0] idtr_q,
	input  logic [exc_pkg::IDX_W-1:0] irq_num_q,
	input  logic ldst_busy,
	input  logic ldst_valid,
	input  logic [exc_pkg::WORD_W-1:0] ldst_data,
	output logic ldst_req,
	output logic [exc_pkg::WORD_W-1:0] ldst_addr,
	output logic read_done,
	output logic [exc_pkg::WORD_W-1:0] handler_addr,
	output logic ict_req,
	output logic [exc_pkg::IDX_W-1:0] ict_entry,
	output logic ict_mask,
	output logic ict_valid,
	output logic [1:0] ict_level
);

	logic active;
	exc_pkg::read_mode_t mode_q;
	// One extra bit so both counters can reach 64
	logic [exc_pkg::IDX_W:0] issue_cnt;
	logic [exc_pkg::IDX_W:0] recv_cnt;
	logic [exc_pkg::IDX_W:0] read_total;
	logic [exc_pkg::IDX_W-1:0] desc_idx;
	logic [exc_pkg::WORD_W-1:0] desc_num;
	logic [exc_pkg::WORD_W-1:0] desc_off;

	always_comb begin
		if (mode_q == exc_pkg::TABLE) begin
			read_total = exc_pkg::IDT_ENTRIES[exc_pkg::IDX_W:0];
			desc_idx = issue_cnt[exc_pkg::IDX_W-1:0];
			desc_off = '0;
		end else begin
			read_total = {{exc_pkg::IDX_W{1'b0}}, 1'b1};
			desc_idx = irq_num_q;
			desc_off = exc_pkg::HANDLER_OFFSET[exc_pkg::WORD_W-1:0];
		end
	end

	assign desc_num = {{(exc_pkg::WORD_W - exc_pkg::IDX_W){1'b0}}, desc_idx};

	// Address only moves after an accepted issue, so it holds under busy
	assign ldst_addr = idtr_q + desc_num * exc_pkg::DESC_STRIDE[exc_pkg::WORD_W-1:0] +
		desc_off;
	assign ldst_req = active && (issue_cnt < read_total);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			active <= 1'b0;
			mode_q <= exc_pkg::NONE;
			issue_cnt <= '0;
			recv_cnt <= '0;
			read_done <= 1'b0;
			ict_req <= 1'b0;
		end else begin
			read_done <= 1'b0;
			ict_req <= 1'b0;
			if (!active) begin
				if (read_start && read_mode != exc_pkg::NONE) begin
					active <= 1'b1;
					mode_q <= read_mode;
					issue_cnt <= '0;
					recv_cnt <= '0;
				end
			end else begin
				if (ldst_req && !ldst_busy) begin
					issue_cnt <= issue_cnt + 1'b1;
				end
				// Issue and receive run independently, several reads in flight
				if (ldst_valid) begin
					recv_cnt <= recv_cnt + 1'b1;
					if (mode_q == exc_pkg::TABLE) begin
						ict_req <= 1'b1;
					end
					if (recv_cnt == read_total - 1'b1) begin
						active <= 1'b0;
						read_done <= 1'b1;
					end
				end
			end
		end
	end

	// Returned words, valid with read_done or ict_req
	always_ff @(posedge iCLOCK) begin
		if (active && ldst_valid) begin
			if (mode_q == exc_pkg::HANDLER) begin
				handler_addr <= ldst_data;
			end else begin
				ict_entry <= recv_cnt[exc_pkg::IDX_W-1:0];
				ict_valid <= ldst_data[exc_pkg::ICT_VALID_BIT];
				ict_mask <= ldst_data[exc_pkg::ICT_MASK_BIT];
				ict_level <= ldst_data[exc_pkg::ICT_LEVEL_LSB +: 2];
			end
		end
	end

endmodule

// File: hw/exception_manager.sv
// Exception sequencer top level.
// Only reads memory; the load/store port is shared with the core while ldst_use is high.
module exception_manager (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic except_jump,
	input  logic except_ib,
	input  logic except_idts,
	input  logic [exc_pkg::WORD_W-1:0] jump_addr,
	input  logic irq_req,
	input  logic [exc_pkg::IDX_W-1:0] irq_num,
	input  logic [exc_pkg::WORD_W-1:0] irq_fi0r,
	input  logic interrupt_lock,
	input  logic [exc_pkg::WORD_W-1:0] psr,
	input  logic [exc_pkg::WORD_W-1:0] pcr,
	input  logic [exc_pkg::WORD_W-1:0] ppcr,
	input  logic [exc_pkg::WORD_W-1:0] idtr,
	input  logic ldst_busy,
	input  logic ldst_valid,
	input  logic [exc_pkg::WORD_W-1:0] ldst_data,
	output logic pipeline_stop,
	output logic refresh,
	output logic pc_set,
	output logic [exc_pkg::WORD_W-1:0] pc,
	output logic ppcr_set,
	output logic [exc_pkg::WORD_W-1:0] ppcr_out,
	output logic fi0r_set,
	output logic [exc_pkg::WORD_W-1:0] fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic irq_ack,
	output logic ldst_use,
	output logic ldst_req,
	output logic [exc_pkg::WORD_W-1:0] ldst_addr,
	output logic ict_req,
	output logic [exc_pkg::IDX_W-1:0] ict_entry,
	output logic ict_mask,
	output logic ict_valid,
	output logic [1:0] ict_level
);

	// FSM to reader handshake
	logic read_start;
	exc_pkg::read_mode_t read_mode;
	logic [exc_pkg::WORD_W-1:0] idtr_q;
	logic [exc_pkg::IDX_W-1:0] irq_num_q;
	logic read_done;
	logic [exc_pkg::WORD_W-1:0] handler_addr;

	exception_ctrl ctrl_i (.*);

	idt_reader reader_i (.*);

endmodule

// File: tests/exception_checker.sv
// Reference model of the exception sequencer, compared at the DUT ports.
// Memory words are taken to be the address XOR MEM_XOR, as the testbench
// memory model returns them. Counts mismatches on the errors output.
module exception_checker #(
	parameter logic [31:0] MEM_XOR = 32'h0
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic except_jump, except_ib, except_idts, irq_req, interrupt_lock,
	input  logic [exc_pkg::WORD_W-1:0] jump_addr, irq_fi0r, psr, pcr, ppcr, idtr,
	input  logic [exc_pkg::IDX_W-1:0] irq_num,
	input  logic pipeline_stop, refresh, pc_set, ppcr_set, fi0r_set,
	input  logic set_irq_mode, clr_irq_mode, irq_ack, ldst_use,
	input  logic ldst_req, ldst_busy,
	input  logic [exc_pkg::WORD_W-1:0] ldst_addr,
	input  logic ict_req, ict_mask, ict_valid,
	input  logic [exc_pkg::WORD_W-1:0] pc, ppcr_out, fi0r,
	input  logic [exc_pkg::IDX_W-1:0] ict_entry,
	input  logic [1:0] ict_level,
	output int errors
);

	exc_pkg::main_state_t mode = exc_pkg::IDLE;
	int err_cnt = 0;
	int cyc;
	int ict_n;
	int fi0r_cyc;
	logic [31:0] exp_pc, exp_ppcr, exp_fi0r, exp_addr, idtr_s, word;
	logic irq_ok, done;

	assign errors = err_cnt;

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			mode = exc_pkg::IDLE;
		end else begin
			done = 1'b0;
			irq_ok = irq_req && !interrupt_lock && psr[exc_pkg::PSR_IRQ_EN_BIT];
			if (mode != exc_pkg::IDLE) begin
				cyc++;
				check("refresh", cyc == 1, refresh);
				case (mode)
					exc_pkg::JUMP: begin
						check("pc_set", cyc == 2, pc_set);
						done = (cyc == 2);
					end
					exc_pkg::IRQ_RET: begin
						check("pc_set", cyc == 3, pc_set);
						check("clr_irq_mode", cyc == 3, clr_irq_mode);
						done = (cyc == 3);
					end
					exc_pkg::IRQ_SET: begin
						check("ppcr_set", cyc == 1, ppcr_set);
						check("set_irq_mode", cyc == 1, set_irq_mode);
						if (cyc == 1) begin
							check("ppcr_out", exp_ppcr, ppcr_out);
						end
						if (fi0r_set) begin
							fi0r_cyc = cyc;
							check("fi0r", exp_fi0r, fi0r);
						end
						check("irq_ack", pc_set, irq_ack);
						if (pc_set) begin
							// fi0r_set must lead pc_set by exactly one cycle
							check("fi0r_set cycle", cyc - 1, fi0r_cyc);
							done = 1'b1;
						end
					end
					default: begin
						if (ict_req) begin
							word = (idtr_s + 32'(ict_n) * 32'd8) ^ MEM_XOR;
							check("ict_entry", ict_n, ict_entry);
							check("ict_valid", word[0], ict_valid);
							check("ict_mask", word[1], ict_mask);
							check("ict_level", word[17:16], ict_level);
							ict_n++;
						end
						if (pc_set) begin
							check("ict_req count", 64, ict_n);
							done = 1'b1;
						end
					end
				endcase
				// Reads go out one descriptor apart, in order
				if (mode == exc_pkg::IRQ_SET || mode == exc_pkg::IDTS) begin
					if (ldst_req && !ldst_busy) begin
						check("ldst_addr", exp_addr, ldst_addr);
						exp_addr = exp_addr + 32'd8;
					end
				end else begin
					check("ldst_req", 0, ldst_req);
				end
				// Strobes foreign to the running event
				if (mode != exc_pkg::IRQ_SET) begin
					check("ppcr_set", 0, ppcr_set);
					check("set_irq_mode", 0, set_irq_mode);
					check("fi0r_set", 0, fi0r_set);
					check("irq_ack", 0, irq_ack);
				end
				if (mode != exc_pkg::IRQ_RET) begin
					check("clr_irq_mode", 0, clr_irq_mode);
				end
				if (mode != exc_pkg::IDTS) begin
					check("ict_req", 0, ict_req);
				end
				if (done) begin
					check("pc", exp_pc, pc);
				end else begin
					check("pipeline_stop", 1, pipeline_stop);
				end
				check("ldst_use", !done && mode != exc_pkg::JUMP, ldst_use);
				if (!done && cyc > 400) begin
					err_cnt++;
					$display("Checker gave up waiting for pc_set after 400 cycles at t=%0t", $time);
					done = 1'b1;
				end
				if (done) begin
					mode = exc_pkg::IDLE;
				end
			end else begin
				check("refresh", 0, refresh);
				check("pc_set", 0, pc_set);
				check("ppcr_set", 0, ppcr_set);
				check("fi0r_set", 0, fi0r_set);
				check("set_irq_mode", 0, set_irq_mode);
				check("clr_irq_mode", 0, clr_irq_mode);
				check("irq_ack", 0, irq_ack);
				check("ict_req", 0, ict_req);
				check("ldst_use", 0, ldst_use);
				check("ldst_req", 0, ldst_req);
			end
			// DUT is in IDLE here and samples the event inputs
			if (mode == exc_pkg::IDLE) begin
				check("pipeline_stop", !except_jump && irq_ok, pipeline_stop);
				cyc = 0;
				fi0r_cyc = 0;
				ict_n = 0;
				idtr_s = idtr;
				if (except_jump) begin
					mode = exc_pkg::JUMP;
					exp_pc = jump_addr;
				end else if (irq_ok) begin
					mode = exc_pkg::IRQ_SET;
					exp_ppcr = pcr;
					exp_fi0r = irq_fi0r;
					exp_addr = idtr + 32'(irq_num) * 32'd8 + 32'd4;
					exp_pc = exp_addr ^ MEM_XOR;
				end else if (except_ib) begin
					mode = exc_pkg::IRQ_RET;
					exp_pc = ppcr;
				end else if (except_idts) begin
					mode = exc_pkg::IDTS;
					exp_addr = idtr;
					exp_pc = jump_addr;
				end
			end
		end
	end

endmodule

// File: tests/exception_manager_sva.sv
// Protocol assertions on the exception FSM strobes.
// Bound into every exception_ctrl instance; inactive while reset is low.
module exception_manager_sva (
	input logic iCLOCK,
	input logic inRESET,
	input logic pc_set,
	input logic set_irq_mode,
	input logic clr_irq_mode
);

	// Number of failed assertions
	int fail_cnt = 0;

	// A PC load lasts one cycle
	pc_set_pulse: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		pc_set |=> !pc_set)
		else begin
			fail_cnt++;
			$error("pc_set stayed high for more than one cycle");
		end

	irq_mode_exclusive: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(set_irq_mode && clr_irq_mode))
		else begin
			fail_cnt++;
			$error("set_irq_mode and clr_irq_mode high in the same cycle");
		end

endmodule

bind exception_ctrl exception_manager_sva sva_i (.*);

// File: tests/tb_exception_manager.sv
// Testbench for the exception sequencer.
// Events are one-cycle strobes from an xorshift stream; their data stays stable
// until the next event. Memory answers in order after 1 to 4 cycles with
// the address XOR MEM_XOR, under random busy.
module tb_exception_manager;

	localparam int CLK_PERIOD = 100;
	localparam int N_EVENTS = 200;
	localparam int EVENT_CYCLES = 400;
	localparam logic [31:0] SEED = 32'hf0072557;
	localparam logic [31:0] MEM_XOR = 32'h5a3c96e1;

	logic iCLOCK, inRESET;
	logic except_jump, except_ib, except_idts, irq_req, interrupt_lock;
	logic [exc_pkg::WORD_W-1:0] jump_addr, irq_fi0r, psr, pcr, ppcr, idtr;
	logic [exc_pkg::IDX_W-1:0] irq_num;
	logic ldst_busy = 1'b0;
	logic ldst_valid = 1'b0;
	logic [exc_pkg::WORD_W-1:0] ldst_data = '0;
	logic pipeline_stop, refresh, pc_set, ppcr_set, fi0r_set;
	logic set_irq_mode, clr_irq_mode, irq_ack, ldst_use, ldst_req;
	logic ict_req, ict_mask, ict_valid;
	logic [exc_pkg::WORD_W-1:0] pc, ppcr_out, fi0r, ldst_addr;
	logic [exc_pkg::IDX_W-1:0] ict_entry;
	logic [1:0] ict_level;
	int errors;

	// Separate streams for stimulus and memory timing
	logic [31:0] stim_rng = SEED;
	logic [31:0] mem_rng = ~SEED;
	logic [31:0] rsp_addr[$];
	int rsp_due[$];
	int now_cyc = 0;
	int last_due = -1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function logic [31:0] next_stim();
		stim_rng = xorshift32(stim_rng);
		return stim_rng;
	endfunction

	exception_manager dut_i (.*);

	exception_checker #(.MEM_XOR(MEM_XOR)) checker_i (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	initial begin
		#(N_EVENTS * EVENT_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before all %0d events completed", N_EVENTS);
		$display("TESTS FAILED");
		$finish;
	end

	// In-order memory model
	always @(posedge iCLOCK) begin
		logic [31:0] addr;
		int due;
		mem_rng = xorshift32(mem_rng);
		now_cyc++;
		ldst_busy <= (mem_rng[1:0] == 2'b00);
		if (inRESET && ldst_req && !ldst_busy) begin
			due = now_cyc + int'(mem_rng[3:2]);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			rsp_addr.push_back(ldst_addr);
			rsp_due.push_back(due);
		end
		if (rsp_due.size() > 0 && rsp_due[0] <= now_cyc) begin
			addr = rsp_addr.pop_front();
			void'(rsp_due.pop_front());
			ldst_valid <= 1'b1;
			ldst_data <= addr ^ MEM_XOR;
		end else begin
			ldst_valid <= 1'b0;
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] p;
		logic qualify;
		int kind;
		inRESET = 1'b0;
		except_jump = 1'b0;
		except_ib = 1'b0;
		except_idts = 1'b0;
		irq_req = 1'b0;
		interrupt_lock = 1'b0;
		irq_num = '0;
		{jump_addr, irq_fi0r, psr, pcr, ppcr, idtr} = '0;
		repeat (2) @(posedge iCLOCK);
		inRESET <= 1'b1;
		for (int i = 0; i < N_EVENTS; i++) begin
			r = next_stim();
			kind = r % 5;
			// Kind 4 offers an interrupt that lock or PSR must block
			qualify = (kind != 4);
			p = next_stim();
			p[exc_pkg::PSR_IRQ_EN_BIT] = qualify || (r[10] && r[11]);
			psr <= p;
			interrupt_lock <= !qualify && r[10];
			except_jump <= (kind == 0);
			irq_req <= (kind == 1) || (kind == 4) || (r[8] && r[9]);
			except_ib <= (kind == 2) || (r[12] && r[13]);
			except_idts <= (kind == 3) || (r[14] && r[15]);
			irq_num <= r[21:16];
			jump_addr <= next_stim();
			irq_fi0r <= next_stim();
			pcr <= next_stim();
			ppcr <= next_stim();
			idtr <= next_stim();
			@(posedge iCLOCK);
			except_jump <= 1'b0;
			except_ib <= 1'b0;
			except_idts <= 1'b0;
			irq_req <= 1'b0;
			@(posedge iCLOCK);
			if (refresh) begin
				while (!pc_set) @(posedge iCLOCK);
			end
		end
		repeat (4) @(posedge iCLOCK);
		$display("Run finished with %0d check errors and %0d assertion failures",
			errors, dut_i.ctrl_i.sva_i.fail_cnt);
		if (errors == 0 && dut_i.ctrl_i.sva_i.fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: sim.f
hw/exc_pkg.sv
hw/exception_ctrl.sv
hw/idt_reader.sv
hw/exception_manager.sv
tests/exception_checker.sv
tests/exception_manager_sva.sv
tests/tb_exception_manager.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and reports the result as exit status
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_exception_manager -o tb_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/tb_sim +verilator+error+limit+1000); then
	echo "$sim_out"
	echo "Simulation exited with an error status"
	exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1
